// ==== verilog.f ====
rtl/ccu_pkg.sv
rtl/isa_word_if.sv
rtl/isa_fetch.sv
rtl/op_length_regs.sv
rtl/engine_cfg_regs.sv
rtl/ccu_top.sv
test/tb_ccu.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_ccu -f verilog.f
out=$(./obj_dir/Vtb_ccu) || true
echo "$out"
if echo "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1

// ==== test/tb_ccu.sv ====
// Self-checking testbench for the configuration control unit with LFSR stimulus
`timescale 1ns/1ps

module tb_ccu import ccu_pkg::*; ();

    logic                       clk;
    logic                       rst_n;
    logic [ISA_WIDTH-1:0]       isa_dat_i;
    logic                       isa_vld_i;
    logic                       isa_rdy_o;
    logic                       knn_cfg_vld_o;
    logic                       knn_cfg_rdy_i;
    logic [IDX_WIDTH-1:0]       knn_nip_o;
    logic [K_WIDTH-1:0]         knn_k_o;
    logic [ADDR_WIDTH-1:0]      knn_crd_rd_addr_o;
    logic [ADDR_WIDTH-1:0]      knn_map_wr_addr_o;
    logic                       sya_cfg_vld_o;
    logic                       sya_cfg_rdy_i;
    logic [ACT_WIDTH-1:0]       sya_shift_o;
    logic [ACT_WIDTH-1:0]       sya_zp_o;
    logic [SYA_MOD_WIDTH-1:0]   sya_mod_o;
    logic                       sya_phase_shift_o;
    logic [CHN_WIDTH-1:0]       sya_chn_o;
    logic [IDX_WIDTH-1:0]       sya_grp_per_tile_o;
    logic [IDX_WIDTH-1:0]       sya_til_flt_o;
    logic [IDX_WIDTH-1:0]       sya_til_ifm_o;
    logic                       sya_lop_ord_o;
    logic [ADDR_WIDTH-1:0]      sya_act_base_o;
    logic [ADDR_WIDTH-1:0]      sya_wgt_base_o;
    logic [ADDR_WIDTH-1:0]      sya_ofm_base_o;
    logic                       itf_cfg_vld_o;
    logic                       itf_cfg_rdy_i;
    logic [DRAM_ADDR_WIDTH-1:0] itf_dram_base_o;
    logic [IDX_WIDTH-1:0]       itf_dram_num_o;

    logic [2:0]           vld_vec;  // {itf, sya, knn}
    logic [2:0]           rdy_vec;
    logic [15:0]          lfsr_q;
    logic [ISA_WIDTH-1:0] sent_w0;
    logic [ISA_WIDTH-1:0] sent_w1;
    int                   xfer_cnt = 0;
    int                   exp_xfers;
    int                   wait_limit;
    string                test_name;

    logic [IDX_WIDTH+K_WIDTH+2*ADDR_WIDTH-1:0]                               exp_knn;
    logic [IDX_WIDTH+K_WIDTH+2*ADDR_WIDTH-1:0]                               act_knn;
    logic [2*ACT_WIDTH+SYA_MOD_WIDTH+CHN_WIDTH+3*IDX_WIDTH+3*ADDR_WIDTH+1:0] exp_sya;
    logic [2*ACT_WIDTH+SYA_MOD_WIDTH+CHN_WIDTH+3*IDX_WIDTH+3*ADDR_WIDTH+1:0] act_sya;
    logic [DRAM_ADDR_WIDTH+IDX_WIDTH-1:0]                                   exp_itf;
    logic [DRAM_ADDR_WIDTH+IDX_WIDTH-1:0]                                   act_itf;

    ccu_top ccu_top_i (.*);

    assign vld_vec = {itf_cfg_vld_o, sya_cfg_vld_o, knn_cfg_vld_o};
    assign {itf_cfg_rdy_i, sya_cfg_rdy_i, knn_cfg_rdy_i} = rdy_vec;

    // Expected fields as slices of the sent words
    assign exp_knn = {sent_w0[KNN_NIP_LSB +: IDX_WIDTH], sent_w0[KNN_K_LSB +: K_WIDTH],
                      sent_w0[KNN_CRD_LSB +: ADDR_WIDTH], sent_w0[KNN_MAP_LSB +: ADDR_WIDTH]};
    assign act_knn = {knn_nip_o, knn_k_o, knn_crd_rd_addr_o, knn_map_wr_addr_o};
    assign exp_sya = {sent_w0[SYA_SHIFT_LSB +: ACT_WIDTH], sent_w0[SYA_ZP_LSB +: ACT_WIDTH],
                      sent_w0[SYA_MOD_LSB +: SYA_MOD_WIDTH], sent_w0[SYA_PHS_LSB],
                      sent_w0[SYA_CHN_LSB +: CHN_WIDTH], sent_w0[SYA_GRP_LSB +: IDX_WIDTH],
                      sent_w0[SYA_TIL_FLT_LSB +: IDX_WIDTH], sent_w0[SYA_TIL_IFM_LSB +: IDX_WIDTH],
                      sent_w0[SYA_LOP_LSB], sent_w0[SYA_ACT_LSB +: ADDR_WIDTH],
                      sent_w1[SYA_WGT_LSB +: ADDR_WIDTH], sent_w1[SYA_OFM_LSB +: ADDR_WIDTH]};
    assign act_sya = {sya_shift_o, sya_zp_o, sya_mod_o, sya_phase_shift_o, sya_chn_o,
                      sya_grp_per_tile_o, sya_til_flt_o, sya_til_ifm_o, sya_lop_ord_o,
                      sya_act_base_o, sya_wgt_base_o, sya_ofm_base_o};
    assign exp_itf = {sent_w0[ITF_BASE_LSB +: DRAM_ADDR_WIDTH], sent_w0[ITF_NUM_LSB +: IDX_WIDTH]};
    assign act_itf = {itf_dram_base_o, itf_dram_num_o};

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Transfer seen half a cycle ahead of its edge
    always @(negedge clk) begin
        if (rst_n && isa_vld_i && isa_rdy_o) xfer_cnt <= xfer_cnt + 1;
    end

    // ============================================================
    // Helpers
    // ============================================================
    task automatic fail_run(input string line);
        $display("%s", line);
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
    endfunction

    task automatic take_bits(input int n, output logic [ISA_WIDTH-1:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[ISA_WIDTH-2:0], lfsr_q[0]};
        end
    endtask

    // Offer one word, return 1 ns after the edge that takes it
    task automatic send_word(input logic [ISA_WIDTH-1:0] w, input bit gaps);
        logic [ISA_WIDTH-1:0] r;
        int                   t;
        if (gaps) begin
            take_bits(2, r);
            repeat (int'(r[1:0])) begin
                @(posedge clk);
                #1;
            end
        end
        isa_dat_i = w;
        isa_vld_i = 1'b1;
        t = 0;
        @(negedge clk);
        while (!isa_rdy_o) begin
            t++;
            if (t > wait_limit) fail_run("Timeout: offered word was never taken");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        isa_vld_i = 1'b0;
    endtask

    task automatic send_instr(input opcode_e op, input int n, input bit gaps);
        logic [ISA_WIDTH-1:0] w;
        exp_xfers = xfer_cnt + n;
        for (int i = 0; i < n; i++) begin
            take_bits(ISA_WIDTH, w);
            if (i == 0) w[OPCODE_WIDTH-1:0] = op;
            if (i == 0) sent_w0 = w;
            if (i == 1) sent_w1 = w;
            send_word(w, gaps);
        end
    endtask

    task automatic serve_engine(input int eng, input bit delay);
        logic [ISA_WIDTH-1:0] r;
        int                   t;
        t = 0;
        @(negedge clk);
        while (!vld_vec[eng]) begin
            t++;
            if (t > wait_limit) fail_run("Timeout: engine config valid never rose");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        if (delay) begin
            take_bits(2, r);
            repeat (int'(r[1:0])) begin
                @(posedge clk);
                #1;
            end
        end
        rdy_vec[eng] = 1'b1;
        @(posedge clk);
        #1;
        rdy_vec[eng] = 1'b0;
        @(negedge clk);
        assert (!vld_vec[eng]) else fail_run("Engine config valid stayed high after its ready");
        @(posedge clk);
        #1;
    endtask

    // CCU and reserved words finish without any engine handshake
    task automatic expect_no_engine();
        repeat (3) begin
            @(negedge clk);
            assert (vld_vec == 3'b000) else fail_run("Engine valid rose for a CCU or reserved word");
        end
        assert (xfer_cnt == exp_xfers)
            else fail_run($sformatf("Fail %s expected %0d actual %0d", test_name, exp_xfers,
                                    xfer_cnt));
        @(posedge clk);
        #1;
    endtask

    // ============================================================
    // Checks
    // ============================================================
    a_knn_fields: assert property (@(posedge clk) disable iff (!rst_n)
        knn_cfg_vld_o |-> act_knn == exp_knn)
        else fail_run($sformatf("Fail %s expected %0h actual %0h", test_name, exp_knn, act_knn));

    a_sya_fields: assert property (@(posedge clk) disable iff (!rst_n)
        sya_cfg_vld_o |-> act_sya == exp_sya)
        else fail_run($sformatf("Fail %s expected %0h actual %0h", test_name, exp_sya, act_sya));

    a_itf_fields: assert property (@(posedge clk) disable iff (!rst_n)
        itf_cfg_vld_o |-> act_itf == exp_itf)
        else fail_run($sformatf("Fail %s expected %0h actual %0h", test_name, exp_itf, act_itf));

    a_sya_stable: assert property (@(posedge clk) disable iff (!rst_n)
        sya_cfg_vld_o && $past(sya_cfg_vld_o) |-> $stable(act_sya))
        else fail_run("SYA fields changed while sya_cfg_vld_o was high");

    a_no_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        (|vld_vec) |-> !isa_rdy_o)
        else fail_run("isa_rdy_o went high while an engine config was pending");

    // Engine valid waits for its own ready
    a_vld_held: assert property (@(posedge clk) disable iff (!rst_n)
        (|vld_vec) && !(|(vld_vec & rdy_vec)) |=> vld_vec == $past(vld_vec))
        else fail_run("Engine config valid fell before its ready was given");

    a_xfer_count: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(|vld_vec) |-> xfer_cnt == exp_xfers)
        else fail_run($sformatf("Fail %s expected %0d actual %0d", test_name, exp_xfers,
                                xfer_cnt));

    // ============================================================
    // Stimulus
    // ============================================================
    initial begin
        logic [ISA_WIDTH-1:0] w;
        rst_n      = 1'b0;
        isa_dat_i  = '0;
        isa_vld_i  = 1'b0;
        rdy_vec    = 3'b000;
        lfsr_q     = 16'd43;
        sent_w0    = '0;
        sent_w1    = '0;
        exp_xfers  = 0;
        wait_limit = 40;
        test_name  = "reset";
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        assert (!isa_rdy_o && vld_vec == 3'b000)
            else fail_run("Handshake outputs not low after reset");
        assert ({act_knn, act_sya, act_itf} == '0)
            else fail_run($sformatf("Fail %s expected 0 actual %0h", test_name,
                                    {act_knn, act_sya, act_itf}));

        test_name = "knn_one_word";
        send_instr(OP_KNN, 1, 1'b0);
        serve_engine(0, 1'b1);

        test_name = "sya_two_words";
        send_instr(OP_SYA, 2, 1'b1);
        serve_engine(1, 1'b1);

        test_name = "ccu_itf_len";
        take_bits(ISA_WIDTH, w);
        w[OPCODE_WIDTH-1:0]                 = OP_CCU;
        w[LEN_KNN_LSB +: NUMWORD_WIDTH]     = 8'd1;
        w[LEN_SYA_LSB +: NUMWORD_WIDTH]     = 8'd2;
        w[LEN_ITF_LSB +: NUMWORD_WIDTH]     = 8'd3;
        exp_xfers = xfer_cnt + 1;
        send_word(w, 1'b0);
        expect_no_engine();
        test_name = "itf_three_words";
        send_instr(OP_ITF, 3, 1'b1);
        serve_engine(2, 1'b1);

        test_name = "reserved_op";
        send_instr(OP_RSV, 1, 1'b0);
        expect_no_engine();
        test_name = "knn_after_reserved";
        send_instr(OP_KNN, 1, 1'b1);
        serve_engine(0, 1'b1);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== rtl/ccu_top.sv ====
// Configuration control unit top: ISA stream in, per-engine config fields out
`timescale 1ns/1ps

module ccu_top import ccu_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,

    input  logic [ISA_WIDTH-1:0]       isa_dat_i,
    input  logic                       isa_vld_i,
    output logic                       isa_rdy_o,

    output logic                       knn_cfg_vld_o,
    input  logic                       knn_cfg_rdy_i,
    output logic [IDX_WIDTH-1:0]       knn_nip_o,
    output logic [K_WIDTH-1:0]         knn_k_o,
    output logic [ADDR_WIDTH-1:0]      knn_crd_rd_addr_o,
    output logic [ADDR_WIDTH-1:0]      knn_map_wr_addr_o,

    output logic                       sya_cfg_vld_o,
    input  logic                       sya_cfg_rdy_i,
    output logic [ACT_WIDTH-1:0]       sya_shift_o,
    output logic [ACT_WIDTH-1:0]       sya_zp_o,
    output logic [SYA_MOD_WIDTH-1:0]   sya_mod_o,
    output logic                       sya_phase_shift_o,
    output logic [CHN_WIDTH-1:0]       sya_chn_o,
    output logic [IDX_WIDTH-1:0]       sya_grp_per_tile_o,
    output logic [IDX_WIDTH-1:0]       sya_til_flt_o,
    output logic [IDX_WIDTH-1:0]       sya_til_ifm_o,
    output logic                       sya_lop_ord_o,
    output logic [ADDR_WIDTH-1:0]      sya_act_base_o,
    output logic [ADDR_WIDTH-1:0]      sya_wgt_base_o,
    output logic [ADDR_WIDTH-1:0]      sya_ofm_base_o,

    output logic                       itf_cfg_vld_o,
    input  logic                       itf_cfg_rdy_i,
    output logic [DRAM_ADDR_WIDTH-1:0] itf_dram_base_o,
    output logic [IDX_WIDTH-1:0]       itf_dram_num_o
);

    logic [NUMWORD_WIDTH-1:0] num_word;  // Count for the latched opcode

    isa_word_if word_bus ();

    isa_fetch u_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .isa_dat_i     (isa_dat_i),
        .isa_vld_i     (isa_vld_i),
        .isa_rdy_o     (isa_rdy_o),
        .num_word_i    (num_word),
        .word          (word_bus.src),
        .knn_cfg_rdy_i (knn_cfg_rdy_i),
        .sya_cfg_rdy_i (sya_cfg_rdy_i),
        .itf_cfg_rdy_i (itf_cfg_rdy_i),
        .knn_cfg_vld_o (knn_cfg_vld_o),
        .sya_cfg_vld_o (sya_cfg_vld_o),
        .itf_cfg_vld_o (itf_cfg_vld_o)
    );

    op_length_regs u_len (
        .clk        (clk),
        .rst_n      (rst_n),
        .word       (word_bus.dst),
        .num_word_o (num_word)
    );

    engine_cfg_regs u_cfg (
        .clk                (clk),
        .rst_n              (rst_n),
        .word               (word_bus.dst),
        .knn_nip_o          (knn_nip_o),
        .knn_k_o            (knn_k_o),
        .knn_crd_rd_addr_o  (knn_crd_rd_addr_o),
        .knn_map_wr_addr_o  (knn_map_wr_addr_o),
        .sya_shift_o        (sya_shift_o),
        .sya_zp_o           (sya_zp_o),
        .sya_mod_o          (sya_mod_o),
        .sya_phase_shift_o  (sya_phase_shift_o),
        .sya_chn_o          (sya_chn_o),
        .sya_grp_per_tile_o (sya_grp_per_tile_o),
        .sya_til_flt_o      (sya_til_flt_o),
        .sya_til_ifm_o      (sya_til_ifm_o),
        .sya_lop_ord_o      (sya_lop_ord_o),
        .sya_act_base_o     (sya_act_base_o),
        .sya_wgt_base_o     (sya_wgt_base_o),
        .sya_ofm_base_o     (sya_ofm_base_o),
        .itf_dram_base_o    (itf_dram_base_o),
        .itf_dram_num_o     (itf_dram_num_o)
    );

endmodule

// ==== rtl/engine_cfg_regs.sv ====
// KNN, SYA and ITF configuration field registers loaded from accepted ISA words
`timescale 1ns/1ps

module engine_cfg_regs import ccu_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    isa_word_if.dst                    word,

    output logic [IDX_WIDTH-1:0]       knn_nip_o,
    output logic [K_WIDTH-1:0]         knn_k_o,
    output logic [ADDR_WIDTH-1:0]      knn_crd_rd_addr_o,
    output logic [ADDR_WIDTH-1:0]      knn_map_wr_addr_o,

    output logic [ACT_WIDTH-1:0]       sya_shift_o,
    output logic [ACT_WIDTH-1:0]       sya_zp_o,
    output logic [SYA_MOD_WIDTH-1:0]   sya_mod_o,
    output logic                       sya_phase_shift_o,
    output logic [CHN_WIDTH-1:0]       sya_chn_o,
    output logic [IDX_WIDTH-1:0]       sya_grp_per_tile_o,
    output logic [IDX_WIDTH-1:0]       sya_til_flt_o,
    output logic [IDX_WIDTH-1:0]       sya_til_ifm_o,
    output logic                       sya_lop_ord_o,
    output logic [ADDR_WIDTH-1:0]      sya_act_base_o,
    output logic [ADDR_WIDTH-1:0]      sya_wgt_base_o,
    output logic [ADDR_WIDTH-1:0]      sya_ofm_base_o,

    output logic [DRAM_ADDR_WIDTH-1:0] itf_dram_base_o,
    output logic [IDX_WIDTH-1:0]       itf_dram_num_o
);

    logic knn_w0;
    logic sya_w0;
    logic sya_w1;
    logic itf_w0;

    // Word decode, higher indices fall through
    assign knn_w0 = word.word_vld && (word.opcode == OP_KNN) && (word.word_idx == 8'd0);
    assign sya_w0 = word.word_vld && (word.opcode == OP_SYA) && (word.word_idx == 8'd0);
    assign sya_w1 = word.word_vld && (word.opcode == OP_SYA) && (word.word_idx == 8'd1);
    assign itf_w0 = word.word_vld && (word.opcode == OP_ITF) && (word.word_idx == 8'd0);

    // ============================================================
    // KNN
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            knn_nip_o         <= '0;
            knn_k_o           <= '0;
            knn_crd_rd_addr_o <= '0;
            knn_map_wr_addr_o <= '0;
        end else if (knn_w0) begin
            knn_nip_o         <= word.data[KNN_NIP_LSB +: IDX_WIDTH];
            knn_k_o           <= word.data[KNN_K_LSB +: K_WIDTH];  // Low bits of slot
            knn_crd_rd_addr_o <= word.data[KNN_CRD_LSB +: ADDR_WIDTH];
            knn_map_wr_addr_o <= word.data[KNN_MAP_LSB +: ADDR_WIDTH];
        end
    end

    // ============================================================
    // SYA
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sya_shift_o        <= '0;
            sya_zp_o           <= '0;
            sya_mod_o          <= '0;
            sya_phase_shift_o  <= 1'b0;
            sya_chn_o          <= '0;
            sya_grp_per_tile_o <= '0;
            sya_til_flt_o      <= '0;
            sya_til_ifm_o      <= '0;
            sya_lop_ord_o      <= 1'b0;
            sya_act_base_o     <= '0;
        end else if (sya_w0) begin
            sya_shift_o        <= word.data[SYA_SHIFT_LSB +: ACT_WIDTH];
            sya_zp_o           <= word.data[SYA_ZP_LSB +: ACT_WIDTH];
            sya_mod_o          <= word.data[SYA_MOD_LSB +: SYA_MOD_WIDTH];
            sya_phase_shift_o  <= word.data[SYA_PHS_LSB];
            sya_chn_o          <= word.data[SYA_CHN_LSB +: CHN_WIDTH];
            sya_grp_per_tile_o <= word.data[SYA_GRP_LSB +: IDX_WIDTH];
            sya_til_flt_o      <= word.data[SYA_TIL_FLT_LSB +: IDX_WIDTH];
            sya_til_ifm_o      <= word.data[SYA_TIL_IFM_LSB +: IDX_WIDTH];
            sya_lop_ord_o      <= word.data[SYA_LOP_LSB];
            sya_act_base_o     <= word.data[SYA_ACT_LSB +: ADDR_WIDTH];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sya_wgt_base_o <= '0;
            sya_ofm_base_o <= '0;
        end else if (sya_w1) begin
            sya_wgt_base_o <= word.data[SYA_WGT_LSB +: ADDR_WIDTH];
            sya_ofm_base_o <= word.data[SYA_OFM_LSB +: ADDR_WIDTH];
        end
    end

    // ============================================================
    // ITF
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            itf_dram_base_o <= '0;
            itf_dram_num_o  <= '0;
        end else if (itf_w0) begin
            itf_dram_base_o <= word.data[ITF_BASE_LSB +: DRAM_ADDR_WIDTH];
            itf_dram_num_o  <= word.data[ITF_NUM_LSB +: IDX_WIDTH];
        end
    end

endmodule

// ==== rtl/op_length_regs.sv ====
// Programmable words-per-opcode table that steers the fetch word counter
`timescale 1ns/1ps

module op_length_regs import ccu_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    isa_word_if.dst                  word,
    output logic [NUMWORD_WIDTH-1:0] num_word_o
);

    logic [NUMWORD_WIDTH-1:0] len_knn_q;
    logic [NUMWORD_WIDTH-1:0] len_sya_q;
    logic [NUMWORD_WIDTH-1:0] len_itf_q;
    logic                     ccu_ld;

    assign ccu_ld = word.word_vld && (word.opcode == OP_CCU) && (word.word_idx == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            len_knn_q <= DEF_LEN_KNN;
            len_sya_q <= DEF_LEN_SYA;
            len_itf_q <= DEF_LEN_ITF;
        end else if (ccu_ld) begin
            len_knn_q <= word.data[LEN_KNN_LSB +: NUMWORD_WIDTH];
            len_sya_q <= word.data[LEN_SYA_LSB +: NUMWORD_WIDTH];
            len_itf_q <= word.data[LEN_ITF_LSB +: NUMWORD_WIDTH];
        end
    end

    always_comb begin
        case (word.opcode)
            OP_KNN:  num_word_o = len_knn_q;
            OP_SYA:  num_word_o = len_sya_q;
            OP_ITF:  num_word_o = len_itf_q;
            default: num_word_o = NUMWORD_WIDTH'(1);  // CCU and reserved
        endcase
    end

    // A zero count would wrap the fetch last-word compare
    a_len_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        ccu_ld |=> (len_knn_q != '0) && (len_sya_q != '0) && (len_itf_q != '0));

endmodule

// ==== rtl/isa_fetch.sv ====
// Instruction fetch FSM with word counter and engine configuration handshake
`timescale 1ns/1ps

module isa_fetch import ccu_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic [ISA_WIDTH-1:0]     isa_dat_i,
    input  logic                     isa_vld_i,
    output logic                     isa_rdy_o,

    input  logic [NUMWORD_WIDTH-1:0] num_word_i,
    isa_word_if.src                  word,

    input  logic                     knn_cfg_rdy_i,
    input  logic                     sya_cfg_rdy_i,
    input  logic                     itf_cfg_rdy_i,
    output logic                     knn_cfg_vld_o,
    output logic                     sya_cfg_vld_o,
    output logic                     itf_cfg_vld_o
);

    fetch_state_e             state_q;
    fetch_state_e             state_d;
    opcode_e                  opcode_q;
    logic [NUMWORD_WIDTH-1:0] word_idx_q;
    logic                     xfer;
    logic                     last_word;
    logic [2:0]               cfg_vld;   // {itf, sya, knn}
    logic [2:0]               cfg_rdy;
    logic                     cfg_done;

    assign isa_rdy_o = (state_q == ST_DEC);
    assign xfer      = isa_vld_i & isa_rdy_o;
    assign last_word = xfer && (word_idx_q == num_word_i - 1'b1);

    // ============================================================
    // Engine valid select
    // ============================================================
    assign cfg_rdy = {itf_cfg_rdy_i, sya_cfg_rdy_i, knn_cfg_rdy_i};

    always_comb begin
        cfg_vld = '0;
        if (state_q == ST_CFG) begin
            case (opcode_q)
                OP_KNN:  cfg_vld[0] = 1'b1;
                OP_SYA:  cfg_vld[1] = 1'b1;
                OP_ITF:  cfg_vld[2] = 1'b1;
                default: cfg_vld = '0;
            endcase
        end
    end

    // CCU and reserved codes acknowledge themselves
    assign cfg_done = (cfg_vld == '0) || (|(cfg_vld & cfg_rdy));

    assign {itf_cfg_vld_o, sya_cfg_vld_o, knn_cfg_vld_o} = cfg_vld;

    // ============================================================
    // FSM
    // ============================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: if (isa_vld_i) state_d = ST_DEC;
            ST_DEC:  if (last_word) state_d = ST_CFG;
            ST_CFG:  if (cfg_done)  state_d = ST_IDLE;
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Opcode peeked from the head word, word not taken yet
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            opcode_q <= OP_CCU;
        end else if (state_q == ST_IDLE && isa_vld_i) begin
            opcode_q <= opcode_e'(isa_dat_i[OPCODE_WIDTH-1:0]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_idx_q <= '0;
        end else if (state_q != ST_DEC) begin
            word_idx_q <= '0;
        end else if (xfer) begin
            word_idx_q <= word_idx_q + 1'b1;
        end
    end

    assign word.word_vld = xfer;
    assign word.opcode   = opcode_q;
    assign word.word_idx = word_idx_q;
    assign word.data     = isa_dat_i;

    // ============================================================
    // Assertions
    // ============================================================
    a_vld_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(cfg_vld));

    // Stream closes right after the last word
    a_rdy_dec_only: assert property (@(posedge clk) disable iff (!rst_n)
        last_word |=> !isa_rdy_o);

    a_vld_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (($past(cfg_vld) & ~$past(cfg_rdy)) & ~cfg_vld) == '0);

endmodule

// ==== rtl/isa_word_if.sv ====
// Accepted instruction word broadcast from the fetch logic to the register blocks
`timescale 1ns/1ps

interface isa_word_if import ccu_pkg::*; ();

    logic                     word_vld;  // One cycle per accepted word
    opcode_e                  opcode;
    logic [NUMWORD_WIDTH-1:0] word_idx;
    logic [ISA_WIDTH-1:0]     data;

    modport src (
        output word_vld,
        output opcode,
        output word_idx,
        output data
    );

    modport dst (
        input word_vld,
        input opcode,
        input word_idx,
        input data
    );

endinterface

// ==== rtl/ccu_pkg.sv ====
// Widths, opcode and state encodings and ISA field offsets of the config control unit
package ccu_pkg;

    // ============================================================
    // Widths
    // ============================================================
    localparam int ISA_WIDTH       = 128;
    localparam int OPCODE_WIDTH    = 8;
    localparam int NUMWORD_WIDTH   = 8;
    localparam int IDX_WIDTH       = 16;
    localparam int ADDR_WIDTH      = 16;
    localparam int DRAM_ADDR_WIDTH = 32;
    localparam int CHN_WIDTH       = 12;
    localparam int ACT_WIDTH       = 8;
    localparam int MAP_WIDTH       = 5;
    localparam int K_WIDTH         = MAP_WIDTH + 1;
    localparam int SYA_MOD_WIDTH   = 2;

    typedef enum logic [OPCODE_WIDTH-1:0] {
        OP_CCU = 8'd0,
        OP_RSV = 8'd1,  // Former sampling code
        OP_KNN = 8'd2,
        OP_SYA = 8'd3,
        OP_ITF = 8'd4
    } opcode_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DEC,
        ST_CFG
    } fetch_state_e;

    // Words per instruction after reset
    localparam logic [NUMWORD_WIDTH-1:0] DEF_LEN_KNN = NUMWORD_WIDTH'(1);
    localparam logic [NUMWORD_WIDTH-1:0] DEF_LEN_SYA = NUMWORD_WIDTH'(2);
    localparam logic [NUMWORD_WIDTH-1:0] DEF_LEN_ITF = NUMWORD_WIDTH'(1);

    // Count bytes inside a CCU word
    localparam int LEN_KNN_LSB = 8;
    localparam int LEN_SYA_LSB = 16;
    localparam int LEN_ITF_LSB = 24;

    // ============================================================
    // Field offsets
    // ============================================================
    localparam int KNN_NIP_LSB     = 8;
    localparam int KNN_K_LSB       = 24;   // 16-bit slot
    localparam int KNN_CRD_LSB     = 40;
    localparam int KNN_MAP_LSB     = 56;

    localparam int SYA_SHIFT_LSB   = 8;
    localparam int SYA_ZP_LSB      = 16;
    localparam int SYA_MOD_LSB     = 24;
    localparam int SYA_PHS_LSB     = 28;
    localparam int SYA_CHN_LSB     = 32;
    localparam int SYA_GRP_LSB     = 44;
    localparam int SYA_TIL_FLT_LSB = 60;
    localparam int SYA_TIL_IFM_LSB = 76;
    localparam int SYA_LOP_LSB     = 92;
    localparam int SYA_ACT_LSB     = 100;
    localparam int SYA_WGT_LSB     = 0;    // Word 1
    localparam int SYA_OFM_LSB     = 16;   // Word 1

    localparam int ITF_BASE_LSB    = 8;
    localparam int ITF_NUM_LSB     = 40;

endpackage
